//--- src.f
+incdir+include
rtl/alu_pkg.sv
rtl/alu_arith.sv
rtl/alu_shift_mul.sv
rtl/alu_output_stage.sv
rtl/alu.sv
tb/tb_alu.sv

//--- run.sh
#!/bin/sh
# builds the ALU testbench with Verilator and runs it
# a $fatal in the testbench gives a non-zero exit status, which this script passes on
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f src.f \
        --top-module tb_alu -o tb_alu \
    && ./obj_dir/tb_alu \
    || { echo "simulation did not pass"; exit 1; }

//--- include/alu_ref_model.svh
/* behavioural reference model of the ALU for the testbench
   include inside a module that imports alu_pkg, flags come back active low as on the pins */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// opcode actually executed once carry-in has been folded in
function automatic alu_op_e fold_carry_in(input alu_op_e op, input logic c_in_n);
    if (!c_in_n) begin
        return op;
    end
    case (op)
        OP_A_ADD_B_C: return OP_A_ADD_B;
        OP_A_SUB_B_C: return OP_A_SUB_B;
        OP_B_SUB_A_C: return OP_B_SUB_A;
        default:      return op;
    endcase
endfunction

// expected byte with carry on top
// arithmetic is done on integers, carry is simply "left the 0..255 range"
function automatic alu_wide_t model_result(input alu_word_t a, input alu_word_t b,
                                           input alu_op_e op, input logic c_in_n);
    alu_op_e   eff;
    alu_word_t v;
    logic      c;
    int        r;
    int        p;
    int        n;
    eff = fold_carry_in(op, c_in_n);
    r = 0;
    p = int'(a) * int'(b);
    v = '0;
    c = 1'b0;
    // counts past 16 give the same outcome as 16 for every shift
    n = (b > 16) ? 16 : int'(b);
    case (eff)
        OP_A:            r = a;
        OP_B:            r = b;
        OP_NEG_A:        r = -int'(a);
        OP_NEG_B:        r = -int'(b);
        OP_A_INC:        r = a + 1;
        OP_B_INC:        r = b + 1;
        OP_A_DEC:        r = a - 1;
        OP_B_DEC:        r = b - 1;
        OP_A_ADD_B:      r = a + b;
        OP_A_SUB_B:      r = a - b;
        OP_B_SUB_A:      r = b - a;
        OP_A_SUB_B_SMAG: r = a - b;
        OP_A_ADD_B_C:    r = a + b + 1;
        OP_A_SUB_B_C:    r = a - b - 1;
        OP_B_SUB_A_C:    r = b - a - 1;
        default:         r = 0;
    endcase
    v = alu_word_t'(r);
    c = (r < 0) || (r > 255);
    case (eff)
        OP_MUL_LO: begin
            v = p[7:0];
            c = (p > 255);
        end
        OP_MUL_HI: v = p[15:8];
        // shifts step one bit at a time and keep the last bit dropped
        OP_LSL: begin
            v = a;
            for (int i = 0; i < n; i++) begin
                c = v[7];
                v = {v[6:0], 1'b0};
            end
        end
        OP_LSR: begin
            v = a;
            for (int i = 0; i < n; i++) begin
                c = v[0];
                v = {1'b0, v[7:1]};
            end
        end
        OP_ASR: begin
            v = a;
            for (int i = 0; i < n; i++) begin
                c = v[0];
                v = {v[7], v[7:1]};
            end
        end
        OP_AND:   v = a & b;
        OP_OR:    v = a | b;
        OP_XOR:   v = a ^ b;
        OP_NOT_A: v = ~a;
        OP_NOT_B: v = ~b;
        default: ;
    endcase
    return {c, v};
endfunction

// overflow means the true signed result has left the -128..127 range
// only the add and subtract ops can raise it
function automatic logic signed_overflow(input alu_word_t a, input alu_word_t b,
                                         input alu_op_e op, input logic c_in_n);
    alu_op_e eff;
    int      sa;
    int      sb;
    int      s;
    eff = fold_carry_in(op, c_in_n);
    sa  = int'($signed(a));
    sb  = int'($signed(b));
    case (eff)
        OP_A_ADD_B:      s = sa + sb;
        OP_A_ADD_B_C:    s = sa + sb + 1;
        OP_A_SUB_B,
        OP_A_SUB_B_SMAG: s = sa - sb;
        OP_A_SUB_B_C:    s = sa - sb - 1;
        OP_B_SUB_A:      s = sb - sa;
        OP_B_SUB_A_C:    s = sb - sa - 1;
        default:         s = 0;
    endcase
    return (s < -128) || (s > 127);
endfunction

// all eight flags, active low, ordered {c, z, n, o, gt, lt, eq, ne}
// greater and less compare the operands as integers, signed only for the signed magnitude op
function automatic logic [7:0] expected_flags_n(input alu_word_t a, input alu_word_t b,
                                                input alu_op_e op, input logic c_in_n);
    alu_wide_t w;
    int        ca;
    int        cb;
    w = model_result(a, b, op, c_in_n);
    if (op == OP_A_SUB_B_SMAG) begin
        ca = int'($signed(a));
        cb = int'($signed(b));
    end else begin
        ca = int'(a);
        cb = int'(b);
    end
    return ~{w[8], (w[7:0] == 8'h00), w[7], signed_overflow(a, b, op, c_in_n),
             (ca > cb), (ca < cb), (a == b), (a != b)};
endfunction

`endif

//--- tb/tb_alu.sv
/* testbench for the registered ALU, random and directed ops checked against the reference model
   run with tb_alu as top, every op is presented on a falling edge and checked one cycle later */
module tb_alu
    import alu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "alu_ref_model.svh"

    // the tests need about 2100 cycles, this leaves room for reset and the directed blocks
    localparam int TIMEOUT_CYCLES = 3000;

    logic      clk;
    logic      arst_n;
    alu_word_t a;
    alu_word_t b;
    alu_op_e   alu_op;
    logic      flag_c_in_n;
    alu_word_t result;
    logic      flag_c_n;
    logic      flag_z_n;
    logic      flag_n_n;
    logic      flag_o_n;
    logic      flag_gt_n;
    logic      flag_lt_n;
    logic      flag_eq_n;
    logic      flag_ne_n;

    // one-cycle expectation pipe and the outputs seen at the last check
    logic       exp_valid;
    alu_word_t  exp_res;
    logic [7:0] exp_flags;
    alu_word_t  got_res;
    logic [7:0] got_flags;
    logic [31:0] lfsr_state;
    int         cycle_count = 0;

    // names for bit i of the packed flag vector, in the order of expected_flags_n
    string   flag_names [0:7] = '{"flag_ne_n", "flag_eq_n", "flag_lt_n", "flag_gt_n",
                                  "flag_o_n", "flag_n_n", "flag_z_n", "flag_c_n"};
    alu_op_e carry_ops [0:2] = '{OP_A_ADD_B_C, OP_A_SUB_B_C, OP_B_SUB_A_C};
    alu_op_e shift_ops [0:2] = '{OP_LSL, OP_LSR, OP_ASR};
    int      shift_counts [0:4] = '{0, 1, 7, 8, 9};

    alu u_alu (
        .clk         (clk),
        .arst_n      (arst_n),
        .a           (a),
        .b           (b),
        .alu_op      (alu_op),
        .flag_c_in_n (flag_c_in_n),
        .result      (result),
        .flag_c_n    (flag_c_n),
        .flag_z_n    (flag_z_n),
        .flag_n_n    (flag_n_n),
        .flag_o_n    (flag_o_n),
        .flag_gt_n   (flag_gt_n),
        .flag_lt_n   (flag_lt_n),
        .flag_eq_n   (flag_eq_n),
        .flag_ne_n   (flag_ne_n)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("timeout, the tests did not finish within the cycle limit");
        end
    end

    // galois LFSR over x^32 + x^22 + x^2 + x + 1 that steps once for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003)
                                       : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] dut_flags();
        return {flag_c_n, flag_z_n, flag_n_n, flag_o_n,
                flag_gt_n, flag_lt_n, flag_eq_n, flag_ne_n};
    endfunction

    // while reset holds the register, the byte is zero and every flag sits inactive
    task automatic check_reset_values();
        logic [7:0] act;
        act = dut_flags();
        assert (result === 8'h00) else
            stop_with_failure($sformatf("ERR result expected %h got %h", 8'h00, result));
        for (int i = 7; i >= 0; i--) begin
            assert (act[i] === 1'b1) else
                stop_with_failure($sformatf("ERR %s expected %h got %h",
                                            flag_names[i], 1'b1, act[i]));
        end
    endtask

    task automatic check_outputs();
        logic [7:0] act;
        act = dut_flags();
        assert (result === exp_res) else
            stop_with_failure($sformatf("ERR result expected %h got %h", exp_res, result));
        for (int i = 7; i >= 0; i--) begin
            assert (act[i] === exp_flags[i]) else
                stop_with_failure($sformatf("ERR %s expected %h got %h",
                                            flag_names[i], exp_flags[i], act[i]));
        end
        got_res   = result;
        got_flags = act;
    endtask

    // checks the op in flight, then presents the next one and queues its expectation
    task automatic apply_op(input alu_word_t op_a, input alu_word_t op_b,
                            input alu_op_e op, input logic c_in_n);
        alu_wide_t w;
        @(negedge clk);
        if (exp_valid) begin
            check_outputs();
        end
        a           = op_a;
        b           = op_b;
        alu_op      = op;
        flag_c_in_n = c_in_n;
        w           = model_result(op_a, op_b, op, c_in_n);
        exp_res     = w[7:0];
        exp_flags   = expected_flags_n(op_a, op_b, op, c_in_n);
        exp_valid   = 1'b1;
    endtask

    task automatic flush_pipe();
        @(negedge clk);
        if (exp_valid) begin
            check_outputs();
        end
        exp_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        alu_word_t   ra;
        alu_word_t   rb;
        alu_word_t   plain_res;
        alu_word_t   delta;
        logic [7:0]  unsigned_flags;
        clk         = 1'b0;
        arst_n      = 1'b0;
        a           = 8'h5a;
        b           = 8'h3c;
        alu_op      = OP_A_ADD_B;
        flag_c_in_n = 1'b1;
        exp_valid   = 1'b0;
        lfsr_state  = 32'hc5e9d8b0;

        // the op on the inputs during reset must not reach the register
        repeat (5) begin
            @(negedge clk);
            check_reset_values();
        end
        arst_n = 1'b1;
        #1;
        check_reset_values();
        exp_res   = 8'h96;
        exp_flags = expected_flags_n(8'h5a, 8'h3c, OP_A_ADD_B, 1'b1);
        exp_valid = 1'b1;

        // a, b, opcode and carry-in are taken from 22 fresh LFSR bits per cycle
        repeat (2000) begin
            rnd = rand_bits(22);
            apply_op(rnd[7:0], rnd[15:8], alu_op_e'(rnd[20:16]), rnd[21]);
        end

        // carry ops with carry-in inactive then active, one fixed and one random pair each
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 2; j++) begin
                rnd = rand_bits(16);
                ra  = (j == 0) ? 8'h7f : rnd[7:0];
                rb  = (j == 0) ? 8'h00 : rnd[15:8];
                apply_op(ra, rb, carry_ops[k], 1'b1);
                apply_op(ra, rb, carry_ops[k], 1'b0);
                plain_res = got_res;
                flush_pipe();
                delta = (carry_ops[k] == OP_A_ADD_B_C) ? 8'h01 : 8'hff;
                assert (got_res == alu_word_t'(plain_res + delta)) else
                    stop_with_failure($sformatf("ERR result expected %h got %h",
                                                alu_word_t'(plain_res + delta), got_res));
            end
        end

        // mixed signs flip greater and less between unsigned and signed compare
        for (int j = 0; j < 3; j++) begin
            ra = (j == 0) ? 8'hfe : ((j == 1) ? 8'h03 : 8'h80);
            rb = (j == 0) ? 8'h03 : ((j == 1) ? 8'hfe : 8'h7f);
            apply_op(ra, rb, OP_A_SUB_B, 1'b1);
            apply_op(ra, rb, OP_A_SUB_B_SMAG, 1'b1);
            unsigned_flags = got_flags;
            flush_pipe();
            assert (unsigned_flags[3:2] == ~got_flags[3:2]) else
                stop_with_failure($sformatf("ERR flag_gt_n/flag_lt_n expected %h got %h",
                                            ~unsigned_flags[3:2], got_flags[3:2]));
        end
        apply_op(8'h55, 8'h55, OP_A_SUB_B_SMAG, 1'b1);

        // shift counts around the byte boundary on a negative operand
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 5; j++) begin
                rnd = rand_bits(8);
                apply_op(rnd[7:0] | 8'h80, alu_word_t'(shift_counts[j]), shift_ops[k], 1'b1);
            end
        end

        // products just below, at and above 256 for the multiply low-byte carry
        apply_op(8'd15, 8'd17, OP_MUL_LO, 1'b1);
        apply_op(8'd16, 8'd16, OP_MUL_LO, 1'b1);
        apply_op(8'd2, 8'd128, OP_MUL_LO, 1'b1);
        apply_op(8'd1, 8'd255, OP_MUL_LO, 1'b1);
        apply_op(8'd0, 8'd255, OP_MUL_LO, 1'b1);
        apply_op(8'd255, 8'd255, OP_MUL_LO, 1'b1);
        flush_pipe();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- rtl/alu.sv
/* top level of the registered 8 bit ALU, wiring the arithmetic, shift/multiply and output units
   inputs are sampled on the rising clk edge and result and flags appear one cycle later */
module alu
    import alu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  alu_word_t a,
    input  alu_word_t b,
    input  alu_op_e   alu_op,
    input  logic      flag_c_in_n,
    output alu_word_t result,
    output logic      flag_c_n,
    output logic      flag_z_n,
    output logic      flag_n_n,
    output logic      flag_o_n,
    output logic      flag_gt_n,
    output logic      flag_lt_n,
    output logic      flag_eq_n,
    output logic      flag_ne_n
);

    // unit results, each zero outside its own opcode group
    alu_wide_t arith_res;
    alu_wide_t shift_mul_res;

    // active high flags from the arithmetic unit
    logic      arith_ovf;
    logic      cmp_gt;
    logic      cmp_lt;
    logic      cmp_eq;

    alu_arith u_arith (
        .a           (a),
        .b           (b),
        .alu_op      (alu_op),
        .flag_c_in_n (flag_c_in_n),
        .arith_res   (arith_res),
        .arith_ovf   (arith_ovf),
        .cmp_gt      (cmp_gt),
        .cmp_lt      (cmp_lt),
        .cmp_eq      (cmp_eq)
    );

    alu_shift_mul u_shift_mul (
        .a             (a),
        .b             (b),
        .alu_op        (alu_op),
        .shift_mul_res (shift_mul_res)
    );

    // the only clocked part, it also owns the logic ops
    alu_output_stage u_output_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .a             (a),
        .b             (b),
        .alu_op        (alu_op),
        .arith_res     (arith_res),
        .shift_mul_res (shift_mul_res),
        .arith_ovf     (arith_ovf),
        .cmp_gt        (cmp_gt),
        .cmp_lt        (cmp_lt),
        .cmp_eq        (cmp_eq),
        .result        (result),
        .flag_c_n      (flag_c_n),
        .flag_z_n      (flag_z_n),
        .flag_n_n      (flag_n_n),
        .flag_o_n      (flag_o_n),
        .flag_gt_n     (flag_gt_n),
        .flag_lt_n     (flag_lt_n),
        .flag_eq_n     (flag_eq_n),
        .flag_ne_n     (flag_ne_n)
    );

endmodule

//--- rtl/alu_output_stage.sv
/* bitwise logic ops, merge of the unit results, flag derivation and the output register
   flags are active high inside and leave the register active low, one cycle after the inputs */
module alu_output_stage
    import alu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  alu_word_t a,
    input  alu_word_t b,
    input  alu_op_e   alu_op,
    input  alu_wide_t arith_res,
    input  alu_wide_t shift_mul_res,
    input  logic      arith_ovf,
    input  logic      cmp_gt,
    input  logic      cmp_lt,
    input  logic      cmp_eq,
    output alu_word_t result,
    output logic      flag_c_n,
    output logic      flag_z_n,
    output logic      flag_n_n,
    output logic      flag_o_n,
    output logic      flag_gt_n,
    output logic      flag_lt_n,
    output logic      flag_eq_n,
    output logic      flag_ne_n
);

    // result of the bitwise ops, zero for every other opcode
    alu_word_t logic_res;

    // merged byte and the active high flags derived from it
    alu_word_t merged_res;
    logic      merged_c;
    logic      merged_z;
    logic      merged_n;
    logic      cmp_ne;

    // logic ops never produce a carry, so only the byte is formed here
    always_comb begin
        case (alu_op)
            OP_AND:   logic_res = a & b;
            OP_OR:    logic_res = a | b;
            OP_XOR:   logic_res = a ^ b;
            OP_NOT_A: logic_res = ~a;
            OP_NOT_B: logic_res = ~b;
            default:  logic_res = '0;
        endcase
    end

    // the opcode groups do not overlap and each unit drives zero outside its own,
    // so a plain OR acts as the result mux
    // unimplemented opcodes fall through every unit and come out as zero
    assign merged_res = arith_res[ALU_W-1:0] | shift_mul_res[ALU_W-1:0] | logic_res;
    assign merged_c   = arith_res[ALU_W] | shift_mul_res[ALU_W];

    // zero and negative always follow the byte that is actually output
    assign merged_z = (merged_res == '0);
    assign merged_n = merged_res[ALU_W-1];

    assign cmp_ne = ~cmp_eq;

    // flag latch of the host CPU, all flags go inactive (high) in reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result    <= '0;
            flag_c_n  <= 1'b1;
            flag_z_n  <= 1'b1;
            flag_n_n  <= 1'b1;
            flag_o_n  <= 1'b1;
            flag_gt_n <= 1'b1;
            flag_lt_n <= 1'b1;
            flag_eq_n <= 1'b1;
            flag_ne_n <= 1'b1;
        end else begin
            result    <= merged_res;
            flag_c_n  <= ~merged_c;
            flag_z_n  <= ~merged_z;
            flag_n_n  <= ~merged_n;
            // overflow only comes from the arithmetic unit
            flag_o_n  <= ~arith_ovf;
            flag_gt_n <= ~cmp_gt;
            flag_lt_n <= ~cmp_lt;
            flag_eq_n <= ~cmp_eq;
            flag_ne_n <= ~cmp_ne;
        end
    end

endmodule

//--- rtl/alu_shift_mul.sv
/* multiplier byte select and the three shifts by b, each with its carry-out
   purely combinational, the result is zero for opcodes outside this group */
module alu_shift_mul
    import alu_pkg::*;
(
    input  alu_word_t a,
    input  alu_word_t b,
    input  alu_op_e   alu_op,
    output alu_wide_t shift_mul_res
);

    // full 16 bit product, only one byte of it is returned per opcode
    logic [2*ALU_W-1:0] product;
    logic               prod_hi_nz;

    // left shift done nine bits wide, bit ALU_W ends up as the carry
    alu_wide_t          lsl_wide;

    // right shift results and the same shifts one step short
    alu_word_t          lsr_word;
    alu_word_t          asr_word;
    alu_word_t          lsr_pre;
    alu_word_t          asr_pre;
    alu_word_t          b_minus_1;

    // carry is the last bit pushed out on the right, none for a zero count
    logic               shift_nz;
    logic               lsr_carry;
    logic               asr_carry;

    assign product    = a * b;
    assign prod_hi_nz = (product[2*ALU_W-1:ALU_W] != '0);

    // bit 8 after the shift is whatever fell off the top of the byte
    // counts of nine or more shift everything out and leave carry clear
    assign lsl_wide = alu_wide_t'(a) << b;

    assign lsr_word = a >> b;
    assign asr_word = alu_word_t'($signed(a) >>> b);

    // b - 1 is only used when b is non-zero, so it never wraps in practice
    assign shift_nz  = (b != '0);
    assign b_minus_1 = b - 1'b1;

    // bit 0 one step before the final shift is the last bit lost
    assign lsr_pre = a >> b_minus_1;
    assign asr_pre = alu_word_t'($signed(a) >>> b_minus_1);

    assign lsr_carry = shift_nz & lsr_pre[0];
    assign asr_carry = shift_nz & asr_pre[0];

    always_comb begin
        case (alu_op)
            // low byte flags a non-zero high byte through carry so software
            // can tell when the full product needs the second op
            OP_MUL_LO: shift_mul_res = {prod_hi_nz, product[ALU_W-1:0]};
            OP_MUL_HI: shift_mul_res = {1'b0, product[2*ALU_W-1:ALU_W]};
            OP_LSL:    shift_mul_res = lsl_wide;
            OP_LSR:    shift_mul_res = {lsr_carry, lsr_word};
            // arithmetic shift keeps filling with the sign, so large counts give 0 or ff
            OP_ASR:    shift_mul_res = {asr_carry, asr_word};
            default:   shift_mul_res = '0;
        endcase
    end

endmodule

//--- rtl/alu_arith.sv
/* adder and subtractor unit with the carry-in bank swap, overflow and the operand comparator
   purely combinational, its result is zero for any opcode outside the arithmetic group */
module alu_arith
    import alu_pkg::*;
(
    input  alu_word_t a,
    input  alu_word_t b,
    input  alu_op_e   alu_op,
    input  logic      flag_c_in_n,
    output alu_wide_t arith_res,
    output logic      arith_ovf,
    output logic      cmp_gt,
    output logic      cmp_lt,
    output logic      cmp_eq
);

    // opcode after the carry-in bank swap
    alu_op_e   op_eff;

    // operands zero extended so bit ALU_W catches carry or borrow
    alu_wide_t a_wide;
    alu_wide_t b_wide;

    // operand and result sign bits used by the overflow rules
    logic      sign_a;
    logic      sign_b;
    logic      sign_r;

    // selects two's complement comparison instead of unsigned
    logic      signed_cmp;

    assign a_wide = {1'b0, a};
    assign b_wide = {1'b0, b};

    // with carry-in inactive the upper bank of carry ops behaves as the plain ops
    // this mirrors the control ROM trick of folding carry-in into the opcode
    always_comb begin
        op_eff = alu_op;
        if (flag_c_in_n) begin
            case (alu_op)
                OP_A_ADD_B_C: op_eff = OP_A_ADD_B;
                OP_A_SUB_B_C: op_eff = OP_A_SUB_B;
                OP_B_SUB_A_C: op_eff = OP_B_SUB_A;
                default:      op_eff = alu_op;
            endcase
        end
    end

    // all arithmetic is done nine bits wide, so a borrow shows up as bit ALU_W set
    always_comb begin
        case (op_eff)
            OP_A:            arith_res = a_wide;
            OP_B:            arith_res = b_wide;
            // negate is 0 - x, borrow is set for any non-zero operand
            OP_NEG_A:        arith_res = -a_wide;
            OP_NEG_B:        arith_res = -b_wide;
            OP_A_INC:        arith_res = a_wide + 1'b1;
            OP_B_INC:        arith_res = b_wide + 1'b1;
            OP_A_DEC:        arith_res = a_wide - 1'b1;
            OP_B_DEC:        arith_res = b_wide - 1'b1;
            OP_A_ADD_B:      arith_res = a_wide + b_wide;
            OP_A_SUB_B:      arith_res = a_wide - b_wide;
            OP_B_SUB_A:      arith_res = b_wide - a_wide;
            OP_A_SUB_B_SMAG: arith_res = a_wide - b_wide;
            // these are only reached with carry-in active, so the extra one is fixed
            OP_A_ADD_B_C:    arith_res = a_wide + b_wide + 1'b1;
            OP_A_SUB_B_C:    arith_res = a_wide - b_wide - 1'b1;
            OP_B_SUB_A_C:    arith_res = b_wide - a_wide - 1'b1;
            default:         arith_res = '0;
        endcase
    end

    assign sign_a = a[ALU_W-1];
    assign sign_b = b[ALU_W-1];
    assign sign_r = arith_res[ALU_W-1];

    // addition overflows when both operands share a sign and the result does not
    // subtraction overflows when left and right differ in sign and the result
    // takes the sign of the right operand
    always_comb begin
        case (op_eff)
            OP_A_ADD_B,
            OP_A_ADD_B_C:    arith_ovf = (sign_a == sign_b) && (sign_r != sign_a);
            OP_A_SUB_B,
            OP_A_SUB_B_C,
            OP_A_SUB_B_SMAG: arith_ovf = (sign_a != sign_b) && (sign_r == sign_b);
            OP_B_SUB_A,
            OP_B_SUB_A_C:    arith_ovf = (sign_b != sign_a) && (sign_r == sign_a);
            default:         arith_ovf = 1'b0;
        endcase
    end

    // the comparator looks at the raw operands, not at the arithmetic result
    // greater and less are unsigned unless the signed magnitude subtract is selected
    assign signed_cmp = (alu_op == OP_A_SUB_B_SMAG);

    assign cmp_eq = (a == b);
    assign cmp_gt = signed_cmp ? ($signed(a) > $signed(b)) : (a > b);
    assign cmp_lt = signed_cmp ? ($signed(a) < $signed(b)) : (a < b);

endmodule

//--- rtl/alu_pkg.sv
/* widths, word types and the opcode encoding shared by the ALU
   every RTL module and the testbench model import this package */
package alu_pkg;

    // width of one data byte on the A, B and result buses
    localparam int ALU_W = 8;

    // width of the opcode field coming from the control unit
    localparam int ALU_OP_W = 5;

    // one operand or result byte
    typedef logic [ALU_W-1:0] alu_word_t;

    // a result byte with its carry or borrow on top, bit ALU_W is the carry
    typedef logic [ALU_W:0] alu_wide_t;

    // full 32 entry opcode map, grouped in four banks of eight like the control ROM
    // divide, modulo, rotates and BCD keep their codes but have no logic behind them
    typedef enum logic [ALU_OP_W-1:0] {
        // bank 0: pass, negate, increment
        OP_ZERO          = 5'd0,
        OP_A             = 5'd1,
        OP_B             = 5'd2,
        OP_NEG_A         = 5'd3,
        OP_NEG_B         = 5'd4,
        OP_A_INC         = 5'd5,
        OP_B_INC         = 5'd6,
        OP_A_DEC         = 5'd7,

        // bank 1: decrement and the add/subtract group
        // the three carry ops fall back to 9..11 when carry-in is inactive
        OP_B_DEC         = 5'd8,
        OP_A_ADD_B       = 5'd9,
        OP_A_SUB_B       = 5'd10,
        OP_B_SUB_A       = 5'd11,
        OP_A_SUB_B_SMAG  = 5'd12,
        OP_A_ADD_B_C     = 5'd13,
        OP_A_SUB_B_C     = 5'd14,
        OP_B_SUB_A_C     = 5'd15,

        // bank 2: multiply, divide and shifts
        OP_MUL_LO        = 5'd16,
        OP_MUL_HI        = 5'd17,
        OP_DIV           = 5'd18,
        OP_MOD           = 5'd19,
        OP_LSL           = 5'd20,
        OP_LSR           = 5'd21,
        OP_ASR           = 5'd22,
        OP_ROL           = 5'd23,

        // bank 3: rotate, bitwise logic and BCD
        OP_ROR           = 5'd24,
        OP_AND           = 5'd25,
        OP_OR            = 5'd26,
        OP_XOR           = 5'd27,
        OP_NOT_A         = 5'd28,
        OP_NOT_B         = 5'd29,
        OP_BCD_ADD       = 5'd30,
        OP_BCD_SUB       = 5'd31
    } alu_op_e;

endpackage
